/* sim.f */
+incdir+common
common/rv_pkg.sv
design/instr_intake.sv
decode/decoder.sv
decode/reg_file.sv
execute/alu_stage.sv
design/retire_unit.sv
design/rv_core_top.sv
dv/tb_rv_core.sv

/* dv/rv_core_patterns.hex */
// Columns: instruction, expected rd, expected data, illegal flag (data unchecked when illegal)
// The all-ones line marks the end of the list
00500093 01 00000005 0
ffd00113 02 fffffffd 0
123451b7 03 12345000 0
67818193 03 12345678 0
fff12213 04 00000001 0
00513293 05 00000000 0
fff0c313 06 fffffffa 0
0f01e393 07 123456f8 0
7ff1f413 08 00000678 0
00409493 09 00000050 0
01c15513 0a 0000000f 0
40115593 0b fffffffe 0
00208633 0c 00000002 0
402086b3 0d 00000008 0
00112733 0e 00000001 0
001137b3 0f 00000000 0
0061c833 10 edcba982 0
001198b3 11 468acf00 0
40135933 12 ffffffff 0
001359b3 13 07ffffff 0
0090ea33 14 00000055 0
0083fab3 15 00000678 0
001a8b13 16 00000679 0
016b0bb3 17 00000cf2 0
416b8bb3 17 00000679 0
00708013 00 0000000c 0
00100c33 18 00000005 0
0000008b 01 00000000 1
021080b3 01 00000000 1
00008c93 19 00000005 0
ffffffff ff ffffffff f

/* dv/tb_rv_core.sv */
`default_nettype none

`include "rv_params.svh"

module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_PATS   = 64;
    localparam int RST_CYCLES = 16;
    localparam logic [31:0] END_MARK = 32'hffffffff;

    logic                        clk;
    logic                        rst;
    logic                        instr_req;
    rv_pkg::word_t               instr_data;
    logic                        instr_ack;
    logic                        retire_valid;
    rv_pkg::reg_addr_t           retire_rd;
    rv_pkg::word_t               retire_data;
    logic                        retire_illegal;
    logic [`RV_RETIRE_CNT_W-1:0] retire_count;

    // Four words per pattern: instruction, rd, data, illegal flag
    logic [31:0] pats [0:4*MAX_PATS-1];

    int     num_pats;
    int     num_sent;
    int     num_retired;
    int     num_passed;
    int     num_errors;
    int     test_errors;
    int     cycles;
    int     cycle_limit;
    integer seed;
    logic   prev_req;
    logic   prev_ack;

    rv_core_top dut0 (
        .clk(clk),
        .rst(rst),
        .instr_req(instr_req),
        .instr_data(instr_data),
        .instr_ack(instr_ack),
        .retire_valid(retire_valid),
        .retire_rd(retire_rd),
        .retire_data(retire_data),
        .retire_illegal(retire_illegal),
        .retire_count(retire_count)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            num_errors++;
            test_errors++;
        end
    endtask

    // True when instr reads the register that prev writes
    function automatic logic reads_result_of(input rv_pkg::word_t instr,
                                             input rv_pkg::word_t prev);
        return (instr[19:15] == prev[11:7]) || (instr[24:20] == prev[11:7]);
    endfunction

    // Full four-phase cycle, entered and left 1 ns after a rising edge
    task automatic send_instr(input rv_pkg::word_t instr);
        instr_data = instr;
        instr_req  = 1'b1;
        @(posedge clk);
        #1;
        while (!instr_ack) begin
            @(posedge clk);
            #1;
        end
        num_sent++;
        instr_req = 1'b0;
        while (instr_ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic score_retired();
        int base;
        base = 4 * num_retired;
        test_errors = 0;
        check_value(retire_illegal, pats[base+3][0], "retire_illegal");
        if (!pats[base+3][0]) begin
            check_value({27'b0, retire_rd}, pats[base+1], "retire_rd");
            check_value(retire_data, pats[base+2], "retire_data");
        end
        $display("Test %0d (instr %h): %s", num_retired, pats[base],
                 (test_errors == 0) ? "ok" : "mismatch");
        if (test_errors == 0) begin
            num_passed++;
        end
        num_retired++;
    endtask

    ////////////////////////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////////////////////////

    // Sampled mid-cycle, away from the edges where signals change
    always @(negedge clk) begin
        if (!rst) begin
            if (instr_ack && !prev_ack && !prev_req) begin
                $display("Handshake error at %0t ns: instr_ack rose with no request", $time);
                num_errors++;
            end
            if (!instr_ack && prev_ack && prev_req) begin
                $display("Handshake error at %0t ns: instr_ack fell before instr_req", $time);
                num_errors++;
            end
            if (retire_valid) begin
                if (num_retired >= num_pats) begin
                    $display("Error at %0t ns: retire_valid with nothing in flight", $time);
                    num_errors++;
                end else begin
                    score_retired();
                end
            end
        end
        prev_req = instr_req;
        prev_ack = instr_ack;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: not every instruction retired within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int gap;
        seed        = 30760;
        rst         = 1'b1;
        instr_req   = 1'b0;
        instr_data  = '0;
        prev_req    = 1'b0;
        prev_ack    = 1'b0;
        num_sent    = 0;
        num_retired = 0;
        num_passed  = 0;
        num_errors  = 0;
        cycles      = 0;
        $readmemh("dv/rv_core_patterns.hex", pats);
        num_pats = 0;
        while (num_pats < MAX_PATS && !$isunknown(pats[4*num_pats])
               && pats[4*num_pats] !== END_MARK) begin
            num_pats++;
        end
        cycle_limit = 20 * num_pats + RST_CYCLES;
        if (num_pats == 0) begin
            $display("No patterns could be read from the pattern file");
        end

        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < num_pats; i++) begin
            // Dependent instructions go out with no gap to stress forwarding
            if (i > 0 && reads_result_of(pats[4*i], pats[4*(i-1)])) begin
                gap = 0;
            end else begin
                gap = $unsigned($random(seed)) % 4;
            end
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            send_instr(pats[4*i]);
        end

        while (num_retired < num_pats) begin
            @(posedge clk);
        end
        // Window for any spurious retire
        repeat (8) @(posedge clk);
        test_errors = 0;
        check_value(32'(retire_count), num_sent, "retire_count");

        $display("%0d tests run, %0d passed, %0d errors", num_pats, num_passed, num_errors);
        if (num_errors == 0 && num_pats > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/rv_core_top.sv */
`default_nettype none

`include "rv_params.svh"

module rv_core_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_req,
    input  rv_pkg::word_t               instr_data,
    output logic                        instr_ack,
    output logic                        retire_valid,
    output rv_pkg::reg_addr_t           retire_rd,
    output rv_pkg::word_t               retire_data,
    output logic                        retire_illegal,
    output logic [`RV_RETIRE_CNT_W-1:0] retire_count
);

    // Intake to decode
    logic              issue_valid;
    rv_pkg::word_t     issue_instr;

    // Decode to register file and execute
    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::reg_addr_t rd_addr;
    rv_pkg::word_t     imm;
    rv_pkg::alu_op_t   alu_op;
    logic              use_imm;
    logic              writes_rd;
    logic              illegal;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;

    // Execute to retire
    logic              x_valid;
    logic              x_writes;
    logic              x_illegal;
    rv_pkg::reg_addr_t x_rd;
    rv_pkg::word_t     x_result;

    // Write-back bus
    logic              wb_we;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::word_t     wb_data;

    ////////////////////////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////////////////////////

    instr_intake u_intake (
        .clk(clk),
        .rst(rst),
        .instr_req(instr_req),
        .instr_data(instr_data),
        .instr_ack(instr_ack),
        .issue_valid(issue_valid),
        .issue_instr(issue_instr)
    );

    decoder u_decoder (
        .issue_instr(issue_instr),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rd_addr(rd_addr),
        .imm(imm),
        .alu_op(alu_op),
        .use_imm(use_imm),
        .writes_rd(writes_rd),
        .illegal(illegal)
    );

    reg_file u_reg_file (
        .clk(clk),
        .rst(rst),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb_we(wb_we),
        .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

    alu_stage u_alu_stage (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rd_addr(rd_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .imm(imm),
        .alu_op(alu_op),
        .use_imm(use_imm),
        .writes_rd(writes_rd),
        .illegal(illegal),
        .wb_we(wb_we),
        .wb_rd(wb_rd),
        .wb_data(wb_data),
        .x_valid(x_valid),
        .x_writes(x_writes),
        .x_illegal(x_illegal),
        .x_rd(x_rd),
        .x_result(x_result)
    );

    retire_unit u_retire (
        .clk(clk),
        .rst(rst),
        .x_valid(x_valid),
        .x_writes(x_writes),
        .x_illegal(x_illegal),
        .x_rd(x_rd),
        .x_result(x_result),
        .wb_we(wb_we),
        .wb_rd(wb_rd),
        .wb_data(wb_data),
        .retire_valid(retire_valid),
        .retire_illegal(retire_illegal),
        .retire_rd(retire_rd),
        .retire_data(retire_data),
        .retire_count(retire_count)
    );

endmodule

`default_nettype wire

/* design/retire_unit.sv */
`default_nettype none

`include "rv_params.svh"

module retire_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        x_valid,
    input  logic                        x_writes,
    input  logic                        x_illegal,
    input  rv_pkg::reg_addr_t           x_rd,
    input  rv_pkg::word_t               x_result,
    output logic                        wb_we,
    output rv_pkg::reg_addr_t           wb_rd,
    output rv_pkg::word_t               wb_data,
    output logic                        retire_valid,
    output logic                        retire_illegal,
    output rv_pkg::reg_addr_t           retire_rd,
    output rv_pkg::word_t               retire_data,
    output logic [`RV_RETIRE_CNT_W-1:0] retire_count
);

    logic ret_writes;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            retire_count <= '0;
        end else begin
            retire_valid <= x_valid;
            // Illegal instructions count as retired too
            if (x_valid) begin
                retire_count <= retire_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (x_valid) begin
            retire_rd      <= x_rd;
            retire_data    <= x_result;
            retire_illegal <= x_illegal;
            ret_writes     <= x_writes;
        end
    end

    // Same register feeds write-back and the retire port
    assign wb_we   = retire_valid && ret_writes;
    assign wb_rd   = retire_rd;
    assign wb_data = retire_data;

endmodule

`default_nettype wire

/* execute/alu_stage.sv */
`default_nettype none

`include "rv_params.svh"

module alu_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t rd_addr,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::word_t     imm,
    input  rv_pkg::alu_op_t   alu_op,
    input  logic              use_imm,
    input  logic              writes_rd,
    input  logic              illegal,
    input  logic              wb_we,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_data,
    output logic              x_valid,
    output logic              x_writes,
    output logic              x_illegal,
    output rv_pkg::reg_addr_t x_rd,
    output rv_pkg::word_t     x_result
);

    // Decode-to-execute register
    logic              de_valid;
    rv_pkg::reg_addr_t de_rs1;
    rv_pkg::reg_addr_t de_rs2;
    rv_pkg::reg_addr_t de_rd;
    rv_pkg::word_t     de_rs1_data;
    rv_pkg::word_t     de_rs2_data;
    rv_pkg::word_t     de_imm;
    rv_pkg::alu_op_t   de_alu_op;
    logic              de_use_imm;
    logic              de_writes;
    logic              de_illegal;

    rv_pkg::word_t                op_a;
    rv_pkg::word_t                op_b;
    rv_pkg::word_t                alu_out;
    logic [$clog2(`RV_XLEN)-1:0]  shamt;

    ////////////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            de_valid <= 1'b0;
            x_valid  <= 1'b0;
        end else begin
            de_valid <= issue_valid;
            x_valid  <= de_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            de_rs1      <= rs1_addr;
            de_rs2      <= rs2_addr;
            de_rd       <= rd_addr;
            de_rs1_data <= rs1_data;
            de_rs2_data <= rs2_data;
            de_imm      <= imm;
            de_alu_op   <= alu_op;
            de_use_imm  <= use_imm;
            de_writes   <= writes_rd;
            de_illegal  <= illegal;
        end
        if (de_valid) begin
            x_rd      <= de_rd;
            x_result  <= alu_out;
            x_writes  <= de_writes;
            x_illegal <= de_illegal;
        end
    end

    ////////////////////////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////////////////////////

    // Result register is newer than the write-back bus
    function automatic rv_pkg::word_t forward(input rv_pkg::reg_addr_t addr,
                                              input rv_pkg::word_t     rf_data);
        if (addr == '0) begin
            return rf_data;
        end
        if (x_valid && x_writes && x_rd == addr) begin
            return x_result;
        end
        if (wb_we && wb_rd == addr) begin
            return wb_data;
        end
        return rf_data;
    endfunction

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        op_a  = forward(de_rs1, de_rs1_data);
        op_b  = de_use_imm ? de_imm : forward(de_rs2, de_rs2_data);
        // Shifts use the low bits only
        shamt = op_b[$clog2(`RV_XLEN)-1:0];
        case (de_alu_op)
            rv_pkg::ALU_ADD:    alu_out = op_a + op_b;
            rv_pkg::ALU_SUB:    alu_out = op_a - op_b;
            rv_pkg::ALU_SLL:    alu_out = op_a << shamt;
            rv_pkg::ALU_SLT:    alu_out = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
            rv_pkg::ALU_SLTU:   alu_out = rv_pkg::word_t'(op_a < op_b);
            rv_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            rv_pkg::ALU_SRL:    alu_out = op_a >> shamt;
            rv_pkg::ALU_SRA:    alu_out = rv_pkg::word_t'($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:     alu_out = op_a | op_b;
            rv_pkg::ALU_AND:    alu_out = op_a & op_b;
            rv_pkg::ALU_PASS_B: alu_out = op_b;
            default:            alu_out = '0;
        endcase
    end

    // Forwarded operands must be resolved by the time a result is valid
    assert property (@(posedge clk) disable iff (rst) x_valid |-> !$isunknown(x_result));

endmodule

`default_nettype wire

/* decode/reg_file.sv */
`default_nettype none

`include "rv_params.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  logic              wb_we,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_data
);

    rv_pkg::word_t regs [`RV_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Write-through read ports
    always_comb begin
        rs1_data = regs[rs1_addr];
        rs2_data = regs[rs2_addr];
        if (wb_we && wb_rd == rs1_addr) begin
            rs1_data = wb_data;
        end
        if (wb_we && wb_rd == rs2_addr) begin
            rs2_data = wb_data;
        end
        // x0 reads as zero
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end
    end

    // Decode strips x0 destinations before they reach write-back
    assert property (@(posedge clk) disable iff (rst) wb_we |-> (wb_rd != '0));

endmodule

`default_nettype wire

/* decode/decoder.sv */
`default_nettype none

module decoder (
    input  rv_pkg::word_t     issue_instr,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::reg_addr_t rd_addr,
    output rv_pkg::word_t     imm,
    output rv_pkg::alu_op_t   alu_op,
    output logic              use_imm,
    output logic              writes_rd,
    output logic              illegal
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_u;

    ////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////

    assign opcode   = issue_instr[6:0];
    assign rd_addr  = issue_instr[11:7];
    assign funct3   = issue_instr[14:12];
    assign rs1_addr = issue_instr[19:15];
    assign rs2_addr = issue_instr[24:20];
    assign funct7   = issue_instr[31:25];

    // I-type is sign extended, U-type fills the upper 20 bits
    assign imm_i = {{20{issue_instr[31]}}, issue_instr[31:20]};
    assign imm_u = {issue_instr[31:12], 12'b0};

    ////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////

    always_comb begin
        alu_op  = rv_pkg::ALU_ADD;
        use_imm = 1'b0;
        imm     = imm_i;
        illegal = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                use_imm = (opcode == rv_pkg::OPC_OP_IMM);
                case (funct3)
                    3'b000: begin
                        // No subi form
                        alu_op = (funct7[5] && !use_imm) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    end
                    3'b001:  alu_op = rv_pkg::ALU_SLL;
                    3'b010:  alu_op = rv_pkg::ALU_SLT;
                    3'b011:  alu_op = rv_pkg::ALU_SLTU;
                    3'b100:  alu_op = rv_pkg::ALU_XOR;
                    3'b101:  alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110:  alu_op = rv_pkg::ALU_OR;
                    default: alu_op = rv_pkg::ALU_AND;
                endcase

                // funct7 is checked on every R-type but only on immediate shifts
                if (!use_imm || funct3 == 3'b001 || funct3 == 3'b101) begin
                    if (funct7 != rv_pkg::F7_BASE && funct7 != rv_pkg::F7_ALT) begin
                        illegal = 1'b1;
                    end else if (funct7 == rv_pkg::F7_ALT && funct3 == 3'b001) begin
                        illegal = 1'b1;
                    end else if (funct7 == rv_pkg::F7_ALT && !use_imm &&
                                 funct3 != 3'b000 && funct3 != 3'b101) begin
                        illegal = 1'b1;
                    end
                end
            end
            rv_pkg::OPC_LUI: begin
                alu_op  = rv_pkg::ALU_PASS_B;
                use_imm = 1'b1;
                imm     = imm_u;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // x0 destinations and illegal opcodes leave the register file alone
    assign writes_rd = !illegal && (rd_addr != '0);

endmodule

`default_nettype wire

/* design/instr_intake.sv */
`default_nettype none

module instr_intake (
    input  logic          clk,
    input  logic          rst,
    input  logic          instr_req,
    input  rv_pkg::word_t instr_data,
    output logic          instr_ack,
    output logic          issue_valid,
    output rv_pkg::word_t issue_instr
);

    // Four-phase receive sequence
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACKED,
        ST_RELEASE
    } state_t;

    state_t state;
    logic   capture;

    // Requests are only sampled while ack is low
    assign capture   = (state == ST_IDLE) && instr_req;
    assign instr_ack = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= capture;
            case (state)
                ST_IDLE: begin
                    if (capture) begin
                        state <= ST_ACKED;
                    end
                end
                ST_ACKED: begin
                    // Hold ack until the sender drops its request
                    if (!instr_req) begin
                        state <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Instruction word stays put until the next handshake
    always_ff @(posedge clk) begin
        if (capture) begin
            issue_instr <= instr_data;
        end
    end

    // Ack only follows a request seen on the previous edge
    assert property (@(posedge clk) disable iff (rst)
        $rose(instr_ack) |-> $past(instr_req));

endmodule

`default_nettype wire

/* common/rv_pkg.sv */
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

    // Data or instruction word
    typedef logic [`RV_XLEN-1:0] word_t;

    // General register index
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // Operation selected by the decoder
    // ALU_PASS_B feeds the lui immediate straight through
    typedef enum logic [`RV_ALU_OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    ////////////////////////////////////////////////////////////
    // RV32I major opcodes
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct7 values
    localparam logic [6:0] F7_BASE = 7'b0000000;
    // Selects sub and sra
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

/* common/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Datapath and instruction word width
`define RV_XLEN 32

// Register index width and register count
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// Retired instruction counter
`define RV_RETIRE_CNT_W 16

// Encoded ALU operation
`define RV_ALU_OP_W 4

`endif
